// ==== mult_top.f ====
common/mult_pkg.sv
hw/pipe_stage.sv
multiplier/csa_tree.sv
multiplier/prefix_adder.sv
hw/mult_top.sv
dv/mult_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the multiplier testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f mult_top.f --top-module mult_tb -o Vmult_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vmult_tb 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Simulation passed$" <<< "$output"; then
  exit 0
else
  echo "Pass message not found in simulation output"
  exit 1
fi

// ==== dv/mult_tb.sv ====
// Testbench for the pipelined multiplier with reference model, scoreboard and watchdog
`timescale 1ns/1ps

module mult_tb;
  import mult_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 10;
  localparam int N_CORNER = 10 + OPERAND_W * OPERAND_W;
  localparam int N_RAND = 2000;
  localparam int TOTAL_ITEMS = N_CORNER + 2 * N_RAND + 2;
  localparam int WATCHDOG_CYCLES = TOTAL_ITEMS * 4 + 200;

  logic      clk;
  logic      rst;
  logic      in_valid;
  logic      in_ready;
  mult_req_t in_req;
  logic      out_valid;
  logic      out_ready;
  mult_rsp_t out_rsp;

  logic       lat_check;                 // Latency and throughput checks for the current burst
  logic [1:0] ready_mode;                // 0 ready high, 1 random, 2 held low
  product_t   exp_q [$];
  int         cyc_q [$];
  logic       lat_q [$];
  int         cycle;
  product_t   exp_val;
  int         in_cyc;
  logic       exp_lat;

  mult_top UUT (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_req    (in_req),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_rsp   (out_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic product_t ref_product(input operand_t a, input operand_t b);
    return product_t'(a) * product_t'(b);
  endfunction

  task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                       input string msg);
    if (actual !== expected) begin
      $display("MISMATCH at %0t ns: %s (got %0h, expected %0h)", $time, msg, actual, expected);
      $display("Simulation failed");
      $fatal(1, "check failed");
    end
  endtask

  // Holds the operands until the DUT takes them
  task automatic send(input operand_t a, input operand_t b);
    in_valid <= 1'b1;
    in_req <= '{a: a, b: b};
    do @(posedge clk); while (!in_ready);
  endtask

  task automatic idle(input int n);
    in_valid <= 1'b0;
    repeat (n) @(posedge clk);
  endtask

  task automatic drain();
    in_valid <= 1'b0;
    do @(posedge clk); while (exp_q.size() != 0);
    repeat (2) @(posedge clk);
  endtask

  always @(posedge clk) begin
    case (ready_mode)
      2'd1: out_ready <= ($urandom_range(0, 2) != 0);  // Low about a third of the time
      2'd2: out_ready <= 1'b0;
      default: out_ready <= 1'b1;
    endcase
  end

  // Scoreboard on the values that were stable before this edge
  always @(posedge clk) begin
    cycle++;
    if (!rst) begin
      if (lat_check && in_valid) begin
        check(64'(in_ready), 64'(1), "input not accepted on a full-rate cycle");
      end
      if (in_valid && in_ready) begin
        exp_q.push_back(ref_product(in_req.a, in_req.b));
        cyc_q.push_back(cycle);
        lat_q.push_back(lat_check);
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          $display("Output transfer at %0t ns with no input pending", $time);
          $display("Simulation failed");
          $fatal(1, "unexpected output");
        end else begin
          exp_val = exp_q.pop_front();
          in_cyc = cyc_q.pop_front();
          exp_lat = lat_q.pop_front();
          check(64'(out_rsp.product), 64'(exp_val), "product");
          if (exp_lat) begin
            check(64'(cycle - in_cyc), 64'(2), "latency in cycles");
          end
        end
      end
    end
  end

  initial begin
    #(CLK_PERIOD * WATCHDOG_CYCLES);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    product_t held;

    void'($urandom(71168));
    rst = 1'b1;
    in_valid = 1'b0;
    in_req = '0;
    out_ready = 1'b1;
    ready_mode = 2'd0;
    lat_check = 1'b0;
    cycle = 0;

    // Stages are unknown until the first reset edge
    for (int i = 0; i < RST_CYCLES; i++) begin
      @(posedge clk);
      if (i > 0) begin
        check(64'(out_valid), 64'(0), "out_valid during reset");
        check(64'(in_ready), 64'(1), "in_ready during reset");
      end
    end
    rst <= 1'b0;
    @(posedge clk);
    check(64'(out_valid), 64'(0), "out_valid after reset");
    check(64'(in_ready), 64'(1), "in_ready after reset");

    send(16'h0000, 16'h0000);
    send(16'h0000, 16'hffff);
    send(16'hffff, 16'h0000);
    send(16'h0001, 16'h1234);
    send(16'hbeef, 16'h0001);
    send(16'hffff, 16'hffff);
    send(16'haaaa, 16'h5555);
    send(16'h5555, 16'haaaa);
    send(16'haaaa, 16'haaaa);
    send(16'h5555, 16'h5555);
    for (int i = 0; i < OPERAND_W; i++) begin
      for (int j = 0; j < OPERAND_W; j++) begin
        send(operand_t'(1) << i, operand_t'(1) << j);
      end
    end
    drain();

    // Full rate with the sink always ready
    lat_check <= 1'b1;
    for (int n = 0; n < N_RAND; n++) begin
      send(16'($urandom), 16'($urandom));
    end
    lat_check <= 1'b0;
    drain();

    ready_mode <= 2'd1;
    for (int n = 0; n < N_RAND; n++) begin
      if ($urandom_range(0, 3) == 0) begin
        idle(int'($urandom_range(1, 3)));
      end
      send(16'($urandom), 16'($urandom));
    end
    ready_mode <= 2'd0;
    drain();

    // Fill both stages against a stalled sink
    ready_mode <= 2'd2;
    repeat (2) @(posedge clk);
    send(16'h1357, 16'h2468);
    send(16'hfedc, 16'h0ba9);
    in_valid <= 1'b0;
    held = ref_product(16'h1357, 16'h2468);
    repeat (4) begin
      @(posedge clk);
      check(64'(in_ready), 64'(0), "in_ready with both stages full");
      check(64'(out_valid), 64'(1), "out_valid while stalled");
      check(64'(out_rsp.product), 64'(held), "out_rsp while stalled");
    end
    ready_mode <= 2'd0;
    drain();

    check(64'(out_valid), 64'(0), "out_valid after the last product");
    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== hw/mult_top.sv ====
// Two stage multiplier, bit heap reduction before the register and prefix add after it
`timescale 1ns/1ps

module mult_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  output logic                in_ready,
  input  mult_pkg::mult_req_t in_req,
  output logic                out_valid,
  input  logic                out_ready,
  output mult_pkg::mult_rsp_t out_rsp
);
  import mult_pkg::*;

  csa_rows_t rows_d;
  csa_rows_t rows_q;
  logic      rows_valid;
  logic      rows_ready;
  mult_rsp_t prod_d;

  csa_tree u_csa (
    .req  (in_req),
    .rows (rows_d)
  );

  // Register boundary sits between the reduction and the carry propagate add
  pipe_stage #(.payload_t(csa_rows_t)) s1_rows (
    .clk      (clk),
    .rst      (rst),
    .up_valid (in_valid),
    .up_ready (in_ready),
    .up_data  (rows_d),
    .dn_valid (rows_valid),
    .dn_ready (rows_ready),
    .dn_data  (rows_q)
  );

  prefix_adder u_add (
    .rows (rows_q),
    .rsp  (prod_d)
  );

  pipe_stage #(.payload_t(mult_rsp_t)) s2_prod (
    .clk      (clk),
    .rst      (rst),
    .up_valid (rows_valid),
    .up_ready (rows_ready),
    .up_data  (prod_d),
    .dn_valid (out_valid),
    .dn_ready (out_ready),
    .dn_data  (out_rsp)
  );

  // An accepted input with the sink ready one cycle later is shown two cycles after entry
  a_latency: assert property (@(posedge clk) disable iff (rst)
    (in_valid && in_ready) ##1 out_ready |=> out_valid)
    else $error("mult_top: product missing two cycles after input");

endmodule

// ==== multiplier/prefix_adder.sv ====
// Sparse tree prefix adder that sums the two reduced rows into the final product
`timescale 1ns/1ps

module prefix_adder (
  input  mult_pkg::csa_rows_t rows,
  output mult_pkg::mult_rsp_t rsp
);
  import mult_pkg::*;

  logic [PRODUCT_W-1:0] gen [PREFIX_LVLS];   // Level l covers bits i down to i - 2**l + 1
  logic [PRODUCT_W-1:0] prop [PREFIX_LVLS];
  product_t             carry;               // carry[i] is the carry out of bit i

  // Aligned group ending at bit i that does not yet reach bit 0
  function automatic logic is_node(input int i, input int l);
    return ((i + 1) % (1 << l) == 0) && ((1 << l) < i + 1);
  endfunction

  // Up-sweep of black cells over spans 2, 4, 8 and 16
  always_comb begin
    logic [1:0] gp;
    int         half;

    for (int l = 0; l < PREFIX_LVLS; l++) begin
      gen[l] = '0;
      prop[l] = '0;
    end
    gen[0] = rows.sum_row & rows.carry_row;
    prop[0] = rows.sum_row ^ rows.carry_row;

    for (int l = 1; l < PREFIX_LVLS; l++) begin
      half = 1 << (l - 1);
      for (int i = 0; i < PRODUCT_W; i++) begin
        if (is_node(i, l)) begin
          gp = black_cell(gen[l-1][i], prop[l-1][i], gen[l-1][i-half], prop[l-1][i-half]);
          gen[l][i] = gp[1];
          prop[l][i] = gp[0];
        end
      end
    end
  end

  // Grey cells join the widest group at bit i with the carry below it
  always_comb begin
    int lvl;

    carry = '0;
    carry[0] = gen[0][0];
    for (int i = 1; i < PRODUCT_W; i++) begin
      lvl = 0;
      for (int l = 1; l < PREFIX_LVLS; l++) begin
        if (is_node(i, l)) begin
          lvl = l;
        end
      end
      carry[i] = grey_cell(gen[lvl][i], prop[lvl][i], carry[i - (1 << lvl)]);
    end
  end

  // Carry out of bit 31 falls off the 32-bit product
  assign rsp.product = prop[0] ^ {carry[PRODUCT_W-2:0], 1'b0};

endmodule

// ==== multiplier/csa_tree.sv ====
// AND array and full/half adder reduction of the partial product bit heap to two rows
`timescale 1ns/1ps

module csa_tree (
  input  mult_pkg::mult_req_t req,
  output mult_pkg::csa_rows_t rows
);
  import mult_pkg::*;

  always_comb begin
    logic [HEAP_H-1:0] heap [PRODUCT_W];     // heap[col] holds bits of weight 2**col
    logic [HEAP_H-1:0] nxt [PRODUCT_W];
    int                cnt [PRODUCT_W];
    int                ncnt [PRODUCT_W];
    logic              b0;
    logic              b1;
    logic              b2;

    for (int col = 0; col < PRODUCT_W; col++) begin
      heap[col] = '0;
      cnt[col] = 0;
    end

    // Partial product a[i] & b[j] lands in column i + j
    for (int i = 0; i < OPERAND_W; i++) begin
      for (int j = 0; j < OPERAND_W; j++) begin
        heap[i+j][cnt[i+j]] = req.a[i] & req.b[j];
        cnt[i+j] = cnt[i+j] + 1;
      end
    end

    // Each round compresses every column in groups of three
    for (int r = 0; r < CSA_ROUNDS; r++) begin
      for (int col = 0; col < PRODUCT_W; col++) begin
        nxt[col] = '0;
        ncnt[col] = 0;
      end

      for (int col = 0; col < PRODUCT_W; col++) begin
        for (int k = 0; k < HEAP_H - 2; k += 3) begin
          b0 = heap[col][k];
          b1 = heap[col][k+1];
          b2 = heap[col][k+2];
          if (k + 2 < cnt[col]) begin
            nxt[col][ncnt[col]] = b0 ^ b1 ^ b2;        // Full adder sum
            ncnt[col] = ncnt[col] + 1;
            if (col + 1 < PRODUCT_W) begin
              nxt[col+1][ncnt[col+1]] = (b0 & b1) | (b2 & (b0 ^ b1));
              ncnt[col+1] = ncnt[col+1] + 1;
            end
          end else if (k + 1 < cnt[col]) begin
            nxt[col][ncnt[col]] = b0 ^ b1;             // Half adder on the leftover pair
            ncnt[col] = ncnt[col] + 1;
            if (col + 1 < PRODUCT_W) begin
              nxt[col+1][ncnt[col+1]] = b0 & b1;
              ncnt[col+1] = ncnt[col+1] + 1;
            end
          end else if (k < cnt[col]) begin
            nxt[col][ncnt[col]] = b0;                  // Single bit passes to the next round
            ncnt[col] = ncnt[col] + 1;
          end
        end
      end

      // Carries out of the top column carry weight 2**32 and drop out
      heap = nxt;
      cnt = ncnt;
    end

    // At most two bits are left per column, unused slots read as zero
    for (int col = 0; col < PRODUCT_W; col++) begin
      rows.sum_row[col] = heap[col][0];
      rows.carry_row[col] = heap[col][1];
    end
  end

endmodule

// ==== hw/pipe_stage.sv ====
// Single valid/ready register slice that holds one item of any payload type
`timescale 1ns/1ps

module pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     up_valid,
  output logic     up_ready,
  input  payload_t up_data,
  output logic     dn_valid,
  input  logic     dn_ready,
  output payload_t dn_data
);

  logic     full;
  payload_t data_q;

  // Free slot, or the held item leaves this cycle
  assign up_ready = !full || dn_ready;
  assign dn_valid = full;
  assign dn_data  = data_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (up_ready) begin
      full <= up_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (up_valid && up_ready) begin
      data_q <= up_data;
    end
  end

  // A stalled item must stay put until the sink takes it
  a_hold: assert property (@(posedge clk) disable iff (rst)
    (dn_valid && !dn_ready) |=> (dn_valid && $stable(dn_data)))
    else $error("pipe_stage: output changed while stalled");

  a_known: assert property (@(posedge clk) disable iff (rst)
    !$isunknown(dn_valid))
    else $error("pipe_stage: dn_valid unknown");

endmodule

// ==== common/mult_pkg.sv ====
// Multiplier package with widths, payload structs and prefix cell functions
package mult_pkg;

  localparam int OPERAND_W = 16;
  localparam int PRODUCT_W = 2 * OPERAND_W;

  // Bit heap sizing for the reduction tree
  localparam int HEAP_H = OPERAND_W + 2;      // Tallest column plus room for a full adder window
  localparam int CSA_ROUNDS = 6;             // 16 -> 11 -> 8 -> 6 -> 4 -> 3 -> 2

  localparam int PREFIX_LVLS = 5;            // Spans 1, 2, 4, 8 and 16

  typedef logic [OPERAND_W-1:0] operand_t;
  typedef logic [PRODUCT_W-1:0] product_t;

  typedef struct packed {
    operand_t a;
    operand_t b;
  } mult_req_t;

  // The two rows add up to the product modulo 2**PRODUCT_W
  typedef struct packed {
    product_t sum_row;
    product_t carry_row;
  } csa_rows_t;

  typedef struct packed {
    product_t product;
  } mult_rsp_t;

  // Returns {g, p} of the merged group
  function automatic logic [1:0] black_cell(input logic g_hi, input logic p_hi,
                                            input logic g_lo, input logic p_lo);
    return {g_hi | (p_hi & g_lo), p_hi & p_lo};
  endfunction

  // Generate only, used once the lower group reaches bit 0
  function automatic logic grey_cell(input logic g_hi, input logic p_hi, input logic g_lo);
    return g_hi | (p_hi & g_lo);
  endfunction

endpackage
